// File: include/soc_macros.svh
// Widths, address map and register offsets of the peripheral subsystem
// The device index is the AXI address above the APB offset bits
// Offsets are byte addresses of full 32-bit registers
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

`define BUS_ADDR_WIDTH       16
`define BUS_DATA_WIDTH       32
`define APB_SLAVE_ADDR_WIDTH 12
`define APB_DEV_COUNT        2
`define GPIO_DEV_IDX         0
`define TMR_DEV_IDX          1

`define GPIO_WIDTH   8
// Line 0 is the timer and wins over line 1 (GPIO)
`define IRQ_COUNT    2
`define IRQ_ID_WIDTH 8

`define GPIO_OUT      12'h000
`define GPIO_DIR      12'h004
`define GPIO_IN       12'h008
`define GPIO_IRQ_EN   12'h00C
`define GPIO_IRQ_STAT 12'h010

`define TMR_CTRL  12'h000
`define TMR_CMP   12'h004
`define TMR_COUNT 12'h008
`define TMR_STAT  12'h00C

`endif

// File: source/soc_bus_pkg.sv
// Bus vector types shared by the AXI-Lite bridge and the APB peripherals
// Responses use AXI encoding, only OKAY and SLVERR are ever produced
`include "soc_macros.svh"

package soc_bus_pkg;

    typedef logic [`BUS_ADDR_WIDTH-1:0]                       addr_t;
    typedef logic [`APB_SLAVE_ADDR_WIDTH-1:0]                 paddr_t;
    typedef logic [`BUS_DATA_WIDTH-1:0]                       data_t;
    typedef logic [`BUS_DATA_WIDTH/8-1:0]                     strb_t;
    typedef logic [1:0]                                       resp_t;
    typedef logic [`APB_DEV_COUNT-1:0]                        dev_sel_t;  // One-hot
    typedef logic [`BUS_ADDR_WIDTH-`APB_SLAVE_ADDR_WIDTH-1:0] dev_idx_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        IDLE,    // Waiting for AW+W or AR
        SETUP,   // APB setup phase
        ACCESS,  // APB access phase
        WRESP,   // B channel valid
        RRESP    // R channel valid
    } bridge_state_e;

endpackage

// File: source/soc_irq_pkg.sv
// Interrupt vector and ID types
// ID 0 means no request, line n is reported as n+1
`include "soc_macros.svh"

package soc_irq_pkg;

    typedef logic [`IRQ_COUNT-1:0]    irq_vec_t;
    typedef logic [`IRQ_ID_WIDTH-1:0] irq_id_t;

    localparam irq_id_t IRQ_ID_NONE = '0;

endpackage

// File: source/apb_if.sv
// APB bus between the bridge and its devices
// Each device drives only its own prdata entry and pready/pslverr bit
`timescale 1ns/100ps
`include "soc_macros.svh"

interface apb_if;

    soc_bus_pkg::dev_sel_t psel;
    logic                  penable;
    soc_bus_pkg::paddr_t   paddr;
    logic                  pwrite;
    soc_bus_pkg::data_t    pwdata;

    // Per-device returns, driven from several modules
    wire soc_bus_pkg::data_t    prdata [`APB_DEV_COUNT];
    wire soc_bus_pkg::dev_sel_t pready;
    wire soc_bus_pkg::dev_sel_t pslverr;

    modport master (
        output psel, penable, paddr, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, paddr, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// File: source/axi2apb.sv
// AXI-Lite slave to APB master bridge, one transfer in flight
// Write wins when AW+W and AR arrive together, WSTRB is ignored
// Response comes 3 cycles after the address handshake unless back-pressured
// Unmapped device index gives SLVERR with zero read data, no APB access
`timescale 1ns/100ps
`include "soc_macros.svh"

module axi2apb (
    input  logic                clk,
    input  logic                rst_n_i,
    input  soc_bus_pkg::addr_t  s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  soc_bus_pkg::data_t  s_wdata_i,
    input  soc_bus_pkg::strb_t  s_wstrb_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output soc_bus_pkg::resp_t  s_bresp_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    input  soc_bus_pkg::addr_t  s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output soc_bus_pkg::data_t  s_rdata_o,
    output soc_bus_pkg::resp_t  s_rresp_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    apb_if.master               apb
);

    soc_bus_pkg::bridge_state_e state_q, state_d;
    logic                       write_q;
    soc_bus_pkg::addr_t         addr_q;
    soc_bus_pkg::data_t         wdata_q;
    soc_bus_pkg::data_t         rdata_q;
    soc_bus_pkg::resp_t         resp_q;

    soc_bus_pkg::dev_idx_t dev_idx;
    logic                  dev_hit;
    soc_bus_pkg::dev_sel_t dev_sel;
    soc_bus_pkg::data_t    sel_rdata;
    logic                  sel_ready;
    logic                  sel_err;
    logic                  wr_take;
    logic                  rd_take;
    logic                  apb_done;

    assign wr_take = (state_q == soc_bus_pkg::IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_take = (state_q == soc_bus_pkg::IDLE) && s_arvalid_i
                     && !(s_awvalid_i && s_wvalid_i);

    assign s_awready_o = wr_take;
    assign s_wready_o  = wr_take;
    assign s_arready_o = rd_take;

    // Address decode on the latched address
    assign dev_idx = addr_q[`BUS_ADDR_WIDTH-1:`APB_SLAVE_ADDR_WIDTH];
    assign dev_hit = dev_idx < `APB_DEV_COUNT;
    assign dev_sel = dev_hit ? soc_bus_pkg::dev_sel_t'(1) << dev_idx : '0;

    always_comb begin
        sel_rdata = '0;    // Unmapped reads return zero
        sel_ready = 1'b1;  // and finish in the usual ACCESS cycle
        sel_err   = 1'b1;
        for (int i = 0; i < `APB_DEV_COUNT; i++) begin
            if (dev_sel[i]) begin
                sel_rdata = apb.prdata[i];
                sel_ready = apb.pready[i];
                sel_err   = apb.pslverr[i];
            end
        end
    end

    assign apb_done = (state_q == soc_bus_pkg::ACCESS) && sel_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            soc_bus_pkg::IDLE:   if (wr_take || rd_take) state_d = soc_bus_pkg::SETUP;
            soc_bus_pkg::SETUP:  state_d = soc_bus_pkg::ACCESS;
            soc_bus_pkg::ACCESS: if (sel_ready) state_d = write_q ? soc_bus_pkg::WRESP
                                                                  : soc_bus_pkg::RRESP;
            soc_bus_pkg::WRESP:  if (s_bready_i) state_d = soc_bus_pkg::IDLE;
            soc_bus_pkg::RRESP:  if (s_rready_i) state_d = soc_bus_pkg::IDLE;
            default:             state_d = soc_bus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= soc_bus_pkg::IDLE;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (wr_take || rd_take) write_q <= wr_take;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            addr_q  <= s_awaddr_i;
            wdata_q <= s_wdata_i;
        end else if (rd_take) begin
            addr_q <= s_araddr_i;
        end
        if (apb_done) begin
            rdata_q <= write_q ? '0 : sel_rdata;
            resp_q  <= sel_err ? soc_bus_pkg::RESP_SLVERR : soc_bus_pkg::RESP_OKAY;
        end
    end

    assign apb.psel    = (state_q == soc_bus_pkg::SETUP || state_q == soc_bus_pkg::ACCESS)
                         ? dev_sel : '0;
    assign apb.penable = state_q == soc_bus_pkg::ACCESS;
    assign apb.paddr   = addr_q[`APB_SLAVE_ADDR_WIDTH-1:0];
    assign apb.pwrite  = write_q;
    assign apb.pwdata  = wdata_q;

    assign s_bvalid_o = state_q == soc_bus_pkg::WRESP;
    assign s_bresp_o  = resp_q;
    assign s_rvalid_o = state_q == soc_bus_pkg::RRESP;
    assign s_rdata_o  = rdata_q;
    assign s_rresp_o  = resp_q;

endmodule

// File: source/apb_gpio.sv
// APB GPIO with output, direction and rising-edge interrupt registers
// Input goes through a two-flop synchronizer before edge detection
// Zero wait states, never signals an error
`timescale 1ns/100ps
`include "soc_macros.svh"

module apb_gpio (
    input  logic                   clk,
    input  logic                   rst_n_i,
    apb_if.slave                   apb,
    input  logic [`GPIO_WIDTH-1:0] gpio_in_i,
    output logic [`GPIO_WIDTH-1:0] gpio_out_o,
    output logic [`GPIO_WIDTH-1:0] gpio_dir_o,
    output logic                   irq_o
);

    logic [`GPIO_WIDTH-1:0] out_q, dir_q, irq_en_q, stat_q;
    logic [`GPIO_WIDTH-1:0] sync1_q, sync2_q, prev_q;
    logic [`GPIO_WIDTH-1:0] rise, stat_clr;
    logic                   wr_en;
    soc_bus_pkg::data_t     rdata;

    assign wr_en    = apb.psel[`GPIO_DEV_IDX] && apb.penable && apb.pwrite;
    assign rise     = sync2_q & ~prev_q & irq_en_q;
    assign stat_clr = (wr_en && apb.paddr == `GPIO_IRQ_STAT) ? apb.pwdata[`GPIO_WIDTH-1:0]
                                                            : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q    <= '0;
            dir_q    <= '0;
            irq_en_q <= '0;
            stat_q   <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            stat_q  <= (stat_q & ~stat_clr) | rise;  // New edge beats the clear
            if (wr_en) begin
                case (apb.paddr)
                    `GPIO_OUT:    out_q    <= apb.pwdata[`GPIO_WIDTH-1:0];
                    `GPIO_DIR:    dir_q    <= apb.pwdata[`GPIO_WIDTH-1:0];
                    `GPIO_IRQ_EN: irq_en_q <= apb.pwdata[`GPIO_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (apb.paddr)
            `GPIO_OUT:      rdata = soc_bus_pkg::data_t'(out_q);
            `GPIO_DIR:      rdata = soc_bus_pkg::data_t'(dir_q);
            `GPIO_IN:       rdata = soc_bus_pkg::data_t'(sync2_q);
            `GPIO_IRQ_EN:   rdata = soc_bus_pkg::data_t'(irq_en_q);
            `GPIO_IRQ_STAT: rdata = soc_bus_pkg::data_t'(stat_q);
            default:        rdata = '0;
        endcase
    end

    assign apb.prdata[`GPIO_DEV_IDX]  = rdata;
    assign apb.pready[`GPIO_DEV_IDX]  = 1'b1;
    assign apb.pslverr[`GPIO_DEV_IDX] = 1'b0;

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign irq_o      = |stat_q;

endmodule

// File: source/apb_timer.sv
// APB compare timer, 32-bit up counter clocked every cycle when enabled
// Count wraps to 0 on compare match and sets a sticky status (W1C)
// Count register is read-only
`timescale 1ns/100ps
`include "soc_macros.svh"

module apb_timer (
    input  logic clk,
    input  logic rst_n_i,
    apb_if.slave apb,
    output logic irq_o
);

    logic               en_q;
    logic               stat_q;
    soc_bus_pkg::data_t cmp_q;
    soc_bus_pkg::data_t count_q;
    logic               match;
    logic               stat_clr;
    logic               wr_en;
    soc_bus_pkg::data_t rdata;

    assign wr_en    = apb.psel[`TMR_DEV_IDX] && apb.penable && apb.pwrite;
    assign match    = en_q && (count_q == cmp_q);
    assign stat_clr = wr_en && (apb.paddr == `TMR_STAT) && apb.pwdata[0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q    <= 1'b0;
            stat_q  <= 1'b0;
            cmp_q   <= '0;
            count_q <= '0;
        end else begin
            if (match) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
            stat_q <= (stat_q && !stat_clr) || match;  // Set wins
            if (wr_en) begin
                case (apb.paddr)
                    `TMR_CTRL: en_q  <= apb.pwdata[0];
                    `TMR_CMP:  cmp_q <= apb.pwdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (apb.paddr)
            `TMR_CTRL:  rdata = soc_bus_pkg::data_t'(en_q);
            `TMR_CMP:   rdata = cmp_q;
            `TMR_COUNT: rdata = count_q;
            `TMR_STAT:  rdata = soc_bus_pkg::data_t'(stat_q);
            default:    rdata = '0;
        endcase
    end

    assign apb.prdata[`TMR_DEV_IDX]  = rdata;
    assign apb.pready[`TMR_DEV_IDX]  = 1'b1;
    assign apb.pslverr[`TMR_DEV_IDX] = 1'b0;

    assign irq_o = stat_q;

endmodule

// File: source/irq_ctrl.sv
// Fixed-priority interrupt encoder, lowest line index wins
// Request and ID are registered, one cycle behind the source vector
`timescale 1ns/100ps
`include "soc_macros.svh"

module irq_ctrl (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  soc_irq_pkg::irq_vec_t irq_vec_i,
    output logic                  irq_req_o,
    output soc_irq_pkg::irq_id_t  irq_id_o
);

    soc_irq_pkg::irq_id_t id_d;

    // Walk down so the lowest active line is the last one written
    always_comb begin
        id_d = soc_irq_pkg::IRQ_ID_NONE;
        for (int i = `IRQ_COUNT - 1; i >= 0; i--) begin
            if (irq_vec_i[i]) id_d = soc_irq_pkg::irq_id_t'(i + 1);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_req_o <= 1'b0;
            irq_id_o  <= soc_irq_pkg::IRQ_ID_NONE;
        end else begin
            irq_req_o <= |irq_vec_i;
            irq_id_o  <= id_d;
        end
    end

endmodule

// File: source/alioth_periph_top.sv
// Peripheral subsystem: AXI-Lite to APB bridge, GPIO, timer and IRQ encoder
// Address bits 15:12 select the device, 0 is GPIO and 1 is the timer
// Interrupt line 0 is the timer, line 1 is GPIO
`timescale 1ns/100ps
`include "soc_macros.svh"

module alioth_periph_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  soc_bus_pkg::addr_t     s_awaddr_i,
    input  logic                   s_awvalid_i,
    output logic                   s_awready_o,
    input  soc_bus_pkg::data_t     s_wdata_i,
    input  soc_bus_pkg::strb_t     s_wstrb_i,
    input  logic                   s_wvalid_i,
    output logic                   s_wready_o,
    output soc_bus_pkg::resp_t     s_bresp_o,
    output logic                   s_bvalid_o,
    input  logic                   s_bready_i,
    input  soc_bus_pkg::addr_t     s_araddr_i,
    input  logic                   s_arvalid_i,
    output logic                   s_arready_o,
    output soc_bus_pkg::data_t     s_rdata_o,
    output soc_bus_pkg::resp_t     s_rresp_o,
    output logic                   s_rvalid_o,
    input  logic                   s_rready_i,
    input  logic [`GPIO_WIDTH-1:0] gpio_in_i,
    output logic [`GPIO_WIDTH-1:0] gpio_out_o,
    output logic [`GPIO_WIDTH-1:0] gpio_dir_o,
    output logic                   irq_req_o,
    output soc_irq_pkg::irq_id_t   irq_id_o
);

    logic                  gpio_irq;
    logic                  tmr_irq;
    soc_irq_pkg::irq_vec_t irq_vec;

    apb_if apb_bus ();

    // AXI port names match the top level one to one
    axi2apb u_axi2apb (.*, .apb(apb_bus));

    apb_gpio u_apb_gpio (.*, .apb(apb_bus), .irq_o(gpio_irq));

    apb_timer u_apb_timer (.*, .apb(apb_bus), .irq_o(tmr_irq));

    assign irq_vec = {gpio_irq, tmr_irq};  // Timer on line 0

    irq_ctrl u_irq_ctrl (.*, .irq_vec_i(irq_vec));

endmodule

// File: tests/alioth_periph_asserts.sv
// Concurrent checks on the top-level ports of the peripheral subsystem
// Latency of 3 cycles holds only for zero-wait-state devices
// Failures are counted in fail_count for the closing summary
`timescale 1ns/100ps
`include "soc_macros.svh"

module alioth_periph_asserts (
    input logic                 clk,
    input logic                 rst_n_i,
    input soc_bus_pkg::addr_t   s_awaddr_i,
    input logic                 s_awvalid_i,
    input logic                 s_awready_o,
    input logic                 s_bvalid_o,
    input soc_bus_pkg::resp_t   s_bresp_o,
    input soc_bus_pkg::addr_t   s_araddr_i,
    input logic                 s_arvalid_i,
    input logic                 s_arready_o,
    input logic                 s_rvalid_o,
    input soc_bus_pkg::resp_t   s_rresp_o,
    input soc_bus_pkg::data_t   s_rdata_o,
    input logic                 irq_req_o,
    input soc_irq_pkg::irq_id_t irq_id_o
);

    int   fail_count = 0;
    logic aw_take, ar_take;
    logic aw_unmapped, ar_unmapped;

    assign aw_take     = s_awvalid_i && s_awready_o;
    assign ar_take     = s_arvalid_i && s_arready_o;
    assign aw_unmapped = s_awaddr_i[`BUS_ADDR_WIDTH-1:`APB_SLAVE_ADDR_WIDTH] >= `APB_DEV_COUNT;
    assign ar_unmapped = s_araddr_i[`BUS_ADDR_WIDTH-1:`APB_SLAVE_ADDR_WIDTH] >= `APB_DEV_COUNT;

    a_wr_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        aw_take |-> ##3 s_bvalid_o)
        else begin
            fail_count++;
            $error("Write response missing 3 cycles after the AW handshake");
        end

    a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_take |-> ##3 s_rvalid_o)
        else begin
            fail_count++;
            $error("Read response missing 3 cycles after the AR handshake");
        end

    a_wr_slverr: assert property (@(posedge clk) disable iff (!rst_n_i)
        aw_take && aw_unmapped |-> ##3 (s_bresp_o == soc_bus_pkg::RESP_SLVERR))
        else begin
            fail_count++;
            $error("Unmapped write did not return SLVERR");
        end

    a_rd_slverr: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_take && ar_unmapped |-> ##3
            (s_rresp_o == soc_bus_pkg::RESP_SLVERR && s_rdata_o == '0))
        else begin
            fail_count++;
            $error("Unmapped read did not return SLVERR with zero data");
        end

    // A request always carries a nonzero ID and vice versa
    a_irq_id: assert property (@(posedge clk) disable iff (!rst_n_i)
        irq_req_o == (irq_id_o != soc_irq_pkg::IRQ_ID_NONE))
        else begin
            fail_count++;
            $error("irq_id_o disagrees with irq_req_o");
        end

endmodule

bind alioth_periph_top alioth_periph_asserts u_asserts (.*);

// File: tests/alioth_periph_tb.sv
// AXI-Lite tasks play the CPU side of the peripheral subsystem
// Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
// Bus and interrupt waits give up after 100 cycles
`timescale 1ns/100ps
`include "soc_macros.svh"

module alioth_periph_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam soc_bus_pkg::data_t GPIO_MASK = (1 << `GPIO_WIDTH) - 1;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    soc_bus_pkg::addr_t     s_awaddr_i;
    logic                   s_awvalid_i;
    logic                   s_awready_o;
    soc_bus_pkg::data_t     s_wdata_i;
    soc_bus_pkg::strb_t     s_wstrb_i;
    logic                   s_wvalid_i;
    logic                   s_wready_o;
    soc_bus_pkg::resp_t     s_bresp_o;
    logic                   s_bvalid_o;
    logic                   s_bready_i;
    soc_bus_pkg::addr_t     s_araddr_i;
    logic                   s_arvalid_i;
    logic                   s_arready_o;
    soc_bus_pkg::data_t     s_rdata_o;
    soc_bus_pkg::resp_t     s_rresp_o;
    logic                   s_rvalid_o;
    logic                   s_rready_i;
    logic [`GPIO_WIDTH-1:0] gpio_in_i;
    logic [`GPIO_WIDTH-1:0] gpio_out_o;
    logic [`GPIO_WIDTH-1:0] gpio_dir_o;
    logic                   irq_req_o;
    soc_irq_pkg::irq_id_t   irq_id_o;

    int                     check_errors = 0;
    int                     timeout_errors = 0;
    int                     total_errors;
    soc_bus_pkg::data_t     rnd_out, rnd_dir, rnd_cmp, cmp_val, rd_data;
    soc_bus_pkg::resp_t     rd_resp;
    logic [`GPIO_WIDTH-1:0] gpio_val;

    always #50 clk = ~clk;  // 100 ns period

    alioth_periph_top alioth_periph_top_i (.*);

    function automatic soc_bus_pkg::addr_t dev_addr(input int idx,
                                                    input soc_bus_pkg::paddr_t off);
        dev_addr = soc_bus_pkg::addr_t'(idx << `APB_SLAVE_ADDR_WIDTH)
                   | soc_bus_pkg::addr_t'(off);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            check_errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Returns just after the edge that carried the address handshake
    task automatic wait_ready(input string name, input bit is_write);
        int n;
        n = 0;
        @(negedge clk);
        while (n < TIMEOUT_CYCLES && !(is_write ? s_awready_o : s_arready_o)) begin
            @(negedge clk);
            n++;
        end
        if (!(is_write ? s_awready_o : s_arready_o)) begin
            $display("Timeout: %s was never accepted by the bridge", name);
            timeout_errors++;
        end
        if (is_write) begin
            check_value({name, " wready"}, 1, s_wready_o);  // Same cycle as AWREADY
        end
        @(posedge clk);
        #1;
    endtask

    // Counts falling edges from the handshake until the response is valid
    task automatic wait_valid(input string name, input bit is_write, output int cycles);
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES && !(is_write ? s_bvalid_o : s_rvalid_o)) begin
            @(negedge clk);
            cycles++;
        end
        if (!(is_write ? s_bvalid_o : s_rvalid_o)) begin
            $display("Timeout: no response arrived for %s", name);
            timeout_errors++;
        end
    endtask

    task automatic write_check(input string name, input soc_bus_pkg::addr_t addr,
                               input soc_bus_pkg::data_t data,
                               input soc_bus_pkg::resp_t exp_resp, input int stall);
        int cycles;
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        s_bready_i  = (stall == 0);
        wait_ready(name, 1'b1);
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        wait_valid(name, 1'b1, cycles);
        check_value({name, " latency"}, 3, cycles);
        check_value({name, " bresp"}, exp_resp, s_bresp_o);
        repeat (stall) begin
            @(negedge clk);
            if (!s_bvalid_o) begin
                $display("BVALID dropped while BREADY was low in %s", name);
                check_errors++;
            end
        end
        if (stall > 0) begin
            @(posedge clk);
            #1;
            s_bready_i = 1'b1;
        end
        @(posedge clk);
        #1;
        s_bready_i = 1'b0;
    endtask

    task automatic axi_read(input string name, input soc_bus_pkg::addr_t addr,
                            output soc_bus_pkg::data_t data, output soc_bus_pkg::resp_t resp);
        int cycles;
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        s_rready_i  = 1'b1;
        wait_ready(name, 1'b0);
        s_arvalid_i = 1'b0;
        wait_valid(name, 1'b0, cycles);
        check_value({name, " latency"}, 3, cycles);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clk);
        #1;
        s_rready_i = 1'b0;
    endtask

    task automatic read_check(input string name, input soc_bus_pkg::addr_t addr,
                              input soc_bus_pkg::data_t exp_data,
                              input soc_bus_pkg::resp_t exp_resp);
        soc_bus_pkg::data_t data;
        soc_bus_pkg::resp_t resp;
        axi_read(name, addr, data, resp);
        check_value({name, " rdata"}, exp_data, data);
        check_value({name, " rresp"}, exp_resp, resp);
    endtask

    task automatic wait_irq_id(input string name, input soc_irq_pkg::irq_id_t exp_id);
        int n;
        n = 0;
        @(negedge clk);
        while (n < TIMEOUT_CYCLES && irq_id_o !== exp_id) begin
            @(negedge clk);
            n++;
        end
        if (irq_id_o !== exp_id) begin
            $display("Timeout: irq_id_o never reached %0d during %s", exp_id, name);
            timeout_errors++;
        end
        check_value({name, " irq_req_o"}, exp_id != 0, irq_req_o);
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n_i     = 1'b0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '1;  // Ignored by the bridge
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        gpio_in_i   = '0;
        rnd_out     = $urandom(58000);  // Seeds the generator
        rnd_dir     = $urandom;
        rnd_cmp     = $urandom;
        idle_cycles(5);
        rst_n_i = 1'b1;

        // Register write and read-back
        write_check("gpio_out write", dev_addr(`GPIO_DEV_IDX, `GPIO_OUT), rnd_out,
                    soc_bus_pkg::RESP_OKAY, 0);
        write_check("gpio_dir write", dev_addr(`GPIO_DEV_IDX, `GPIO_DIR), rnd_dir,
                    soc_bus_pkg::RESP_OKAY, 0);
        write_check("tmr_cmp write", dev_addr(`TMR_DEV_IDX, `TMR_CMP), rnd_cmp,
                    soc_bus_pkg::RESP_OKAY, 0);
        read_check("gpio_out read", dev_addr(`GPIO_DEV_IDX, `GPIO_OUT), rnd_out & GPIO_MASK,
                   soc_bus_pkg::RESP_OKAY);
        read_check("gpio_dir read", dev_addr(`GPIO_DEV_IDX, `GPIO_DIR), rnd_dir & GPIO_MASK,
                   soc_bus_pkg::RESP_OKAY);
        read_check("tmr_cmp read", dev_addr(`TMR_DEV_IDX, `TMR_CMP), rnd_cmp,
                   soc_bus_pkg::RESP_OKAY);
        check_value("gpio_out_o pins", rnd_out & GPIO_MASK, gpio_out_o);
        check_value("gpio_dir_o pins", rnd_dir & GPIO_MASK, gpio_dir_o);

        // B channel held off by a low BREADY
        write_check("stalled write", dev_addr(`GPIO_DEV_IDX, `GPIO_DIR), rnd_dir,
                    soc_bus_pkg::RESP_OKAY, 4);

        // Device index 2 and above is unmapped
        write_check("unmapped write", dev_addr(2, `GPIO_OUT), ~rnd_out,
                    soc_bus_pkg::RESP_SLVERR, 0);
        read_check("unmapped read", dev_addr(2, `GPIO_OUT), '0, soc_bus_pkg::RESP_SLVERR);
        read_check("unmapped top read", dev_addr(15, `TMR_CMP), '0, soc_bus_pkg::RESP_SLVERR);
        read_check("gpio_out kept", dev_addr(`GPIO_DEV_IDX, `GPIO_OUT), rnd_out & GPIO_MASK,
                   soc_bus_pkg::RESP_OKAY);
        check_value("gpio_out_o kept", rnd_out & GPIO_MASK, gpio_out_o);

        // GPIO input and rising-edge interrupt on bit 0
        gpio_val  = `GPIO_WIDTH'($urandom) & ~`GPIO_WIDTH'(1);
        gpio_in_i = gpio_val;
        idle_cycles(2);  // Two-flop synchronizer
        read_check("gpio_in read", dev_addr(`GPIO_DEV_IDX, `GPIO_IN), gpio_val,
                   soc_bus_pkg::RESP_OKAY);
        write_check("gpio_irq_en write", dev_addr(`GPIO_DEV_IDX, `GPIO_IRQ_EN), 1,
                    soc_bus_pkg::RESP_OKAY, 0);
        gpio_in_i = gpio_val | 1'b1;
        wait_irq_id("gpio edge", 2);
        read_check("gpio_stat set", dev_addr(`GPIO_DEV_IDX, `GPIO_IRQ_STAT), 1,
                   soc_bus_pkg::RESP_OKAY);
        write_check("gpio_stat clear", dev_addr(`GPIO_DEV_IDX, `GPIO_IRQ_STAT), 1,
                    soc_bus_pkg::RESP_OKAY, 0);
        wait_irq_id("gpio cleared", 0);
        read_check("gpio_stat after clear", dev_addr(`GPIO_DEV_IDX, `GPIO_IRQ_STAT), 0,
                   soc_bus_pkg::RESP_OKAY);

        // Timer match while a GPIO request is pending
        gpio_in_i = gpio_val;
        idle_cycles(3);
        gpio_in_i = gpio_val | 1'b1;
        wait_irq_id("gpio edge again", 2);
        cmp_val = 8 + ($urandom % 16);
        write_check("tmr_cmp set", dev_addr(`TMR_DEV_IDX, `TMR_CMP), cmp_val,
                    soc_bus_pkg::RESP_OKAY, 0);
        write_check("tmr enable", dev_addr(`TMR_DEV_IDX, `TMR_CTRL), 1,
                    soc_bus_pkg::RESP_OKAY, 0);
        wait_irq_id("timer priority", 1);
        write_check("tmr disable", dev_addr(`TMR_DEV_IDX, `TMR_CTRL), 0,
                    soc_bus_pkg::RESP_OKAY, 0);
        read_check("tmr_stat set", dev_addr(`TMR_DEV_IDX, `TMR_STAT), 1,
                   soc_bus_pkg::RESP_OKAY);
        axi_read("tmr_count read", dev_addr(`TMR_DEV_IDX, `TMR_COUNT), rd_data, rd_resp);
        check_value("tmr_count rresp", soc_bus_pkg::RESP_OKAY, rd_resp);
        if (rd_data > cmp_val) begin
            $display("[FAIL] timer wrap: expected count <= 0x%08h, actual 0x%08h",
                     cmp_val, rd_data);
            check_errors++;
        end
        write_check("tmr_stat clear", dev_addr(`TMR_DEV_IDX, `TMR_STAT), 1,
                    soc_bus_pkg::RESP_OKAY, 0);
        wait_irq_id("timer cleared", 2);
        write_check("gpio_stat final clear", dev_addr(`GPIO_DEV_IDX, `GPIO_IRQ_STAT), 1,
                    soc_bus_pkg::RESP_OKAY, 0);
        wait_irq_id("all cleared", 0);

        idle_cycles(5);  // Let pending assertions complete
        total_errors = check_errors + timeout_errors + alioth_periph_top_i.u_asserts.fail_count;
        $display("Errors: %0d check, %0d timeout, %0d assertion", check_errors,
                 timeout_errors, alioth_periph_top_i.u_asserts.fail_count);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
source/soc_bus_pkg.sv
source/soc_irq_pkg.sv
source/apb_if.sv
source/axi2apb.sv
source/apb_gpio.sv
source/apb_timer.sv
source/irq_ctrl.sv
source/alioth_periph_top.sv
tests/alioth_periph_asserts.sv
tests/alioth_periph_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module alioth_periph_tb

# Assertion errors must not stop the run before the summary line
output=$(./obj_dir/Valioth_periph_tb +verilator+error+limit+1000 || true)
echo "$output"

echo "$output" | grep -q "TEST RESULT: PASS"
